//--- design/lq_pkg.sv
package lq_pkg;

    localparam int ROB_IDX_W = 5;
    localparam int PRF_IDX_W = 6;

    // defaults, the top level may override
    localparam int DEF_NUM_ENTRIES = 8;
    localparam int DEF_WAYS = 2;

    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_t;

    // per-entry life cycle
    typedef enum logic [2:0] {
        ST_FREE      = 3'd0,
        ST_WAIT_ADDR = 3'd1,
        ST_READY     = 3'd2,
        ST_WAIT_MEM  = 3'd3,
        ST_DONE      = 3'd4
    } ld_state_t;

    typedef struct packed {
        mem_size_t              size;
        logic [ROB_IDX_W-1:0]   rob_idx;
        logic [PRF_IDX_W-1:0]   prf_idx;
        logic                   is_signed;
    } ld_issue_t;

    typedef struct packed {
        addr_t      addr;
        mem_size_t  size;
    } cache_req_t;

    typedef struct packed {
        data_t                  data;
        logic [PRF_IDX_W-1:0]   prf_idx;
        logic [ROB_IDX_W-1:0]   rob_idx;
        mem_size_t              size;
        logic                   is_signed;
    } cdb_payload_t;

endpackage

//--- design/lq_entry_if.sv
interface lq_entry_if #(
    parameter int N = lq_pkg::DEF_NUM_ENTRIES
);

    // entry status, seen by the two arbiters
    logic [N-1:0]                   ready;
    logic [N-1:0]                   done;
    lq_pkg::cache_req_t [N-1:0]     cache_req;
    lq_pkg::cdb_payload_t [N-1:0]   cdb_pl;

    // one-hot grants back into the array
    logic [N-1:0]                   rd_gnt;
    logic [N-1:0]                   cdb_gnt;

    modport array (
        output ready,
        output done,
        output cache_req,
        output cdb_pl,
        input  rd_gnt,
        input  cdb_gnt
    );

    modport port (
        input  ready,
        input  done,
        input  cache_req,
        input  cdb_pl,
        output rd_gnt,
        output cdb_gnt
    );

endinterface

//--- design/lq_alloc.sv
module lq_alloc #(
    parameter int NUM_ENTRIES = lq_pkg::DEF_NUM_ENTRIES,
    parameter int WAYS = lq_pkg::DEF_WAYS
) (
    input  logic [NUM_ENTRIES-1:0]                  free_mask,
    input  logic [WAYS-1:0]                         ld_en,
    input  lq_pkg::ld_issue_t [WAYS-1:0]            ld_info,
    output logic [NUM_ENTRIES-1:0]                  alloc_en,
    output lq_pkg::ld_issue_t [NUM_ENTRIES-1:0]     alloc_info
);

    // which entry each way landed in
    logic [WAYS-1:0][NUM_ENTRIES-1:0] way_gnt;

    always_comb begin
        logic [NUM_ENTRIES-1:0] avail;
        logic taken;
        avail = free_mask;
        alloc_en = '0;
        alloc_info = '0;
        way_gnt = '0;
        // way 0 first, each way takes the lowest entry still open
        for (int w = 0; w < WAYS; w++) begin
            taken = 1'b0;
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                if (ld_en[w] && !taken && avail[e]) begin
                    alloc_en[e] = 1'b1;
                    alloc_info[e] = ld_info[w];
                    avail[e] = 1'b0;
                    way_gnt[w][e] = 1'b1;
                    taken = 1'b1;
                end
            end
        end
    end

    // an entry may belong to one way at most
    always_comb begin
        logic [WAYS-1:0] owners;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            for (int w = 0; w < WAYS; w++) begin
                owners[w] = way_gnt[w][e];
            end
            a_single_owner: assert ($onehot0(owners))
                else $error("entry %0d granted to more than one way", e);
        end
    end

endmodule

//--- design/lq_grant_mux.sv
module lq_grant_mux #(
    parameter int WIDTH = lq_pkg::DEF_NUM_ENTRIES,
    parameter type payload_t = logic
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic [WIDTH-1:0]        req,
    input  payload_t [WIDTH-1:0]    payload,
    output logic [WIDTH-1:0]        gnt,
    output logic                    valid,
    output payload_t                sel
);

    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // index of the last winner
    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] win_idx;

    // search begins just past the last winner and wraps
    always_comb begin
        int unsigned idx;
        gnt = '0;
        win_idx = '0;
        for (int k = 1; k <= WIDTH; k++) begin
            idx = (int'(last_q) + k) % WIDTH;
            if (gnt == '0 && req[idx]) begin
                gnt[idx] = 1'b1;
                win_idx = IDX_W'(idx);
            end
        end
    end

    assign valid = |gnt;
    assign sel = payload[win_idx];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // first search after reset starts at index 0
            last_q <= IDX_W'(WIDTH - 1);
        end else if (valid) begin
            last_q <= win_idx;
        end
    end

    a_gnt_onehot: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(gnt))
        else $error("grant not one-hot");

endmodule

//--- design/lq_entry_array.sv
module lq_entry_array #(
    parameter int NUM_ENTRIES = lq_pkg::DEF_NUM_ENTRIES,
    parameter int WAYS = lq_pkg::DEF_WAYS
) (
    input  logic                                        clock,
    input  logic                                        arst_n,
    input  logic                                        except,
    input  logic [NUM_ENTRIES-1:0]                      alloc_en,
    input  lq_pkg::ld_issue_t [NUM_ENTRIES-1:0]         alloc_info,
    input  logic [WAYS-1:0]                             alu_valid,
    input  logic [WAYS-1:0]                             alu_is_ls,
    input  logic [WAYS-1:0][lq_pkg::ROB_IDX_W-1:0]      alu_rob_idx,
    input  lq_pkg::addr_t [WAYS-1:0]                    alu_data,
    input  logic                                        dc_hit,
    input  lq_pkg::data_t                               dc_data,
    input  logic [NUM_ENTRIES-1:0]                      mem_feedback,
    input  lq_pkg::data_t                               mem_data,
    output logic [NUM_ENTRIES-1:0]                      free_mask,
    output logic [$clog2(NUM_ENTRIES+1)-1:0]            lq_num_free,
    lq_entry_if.array                                   ifc
);

    localparam int CNT_W = $clog2(NUM_ENTRIES + 1);

    lq_pkg::ld_state_t  state_q [NUM_ENTRIES];
    lq_pkg::ld_state_t  state_d [NUM_ENTRIES];
    lq_pkg::addr_t      addr_q [NUM_ENTRIES];
    lq_pkg::ld_issue_t  info_q [NUM_ENTRIES];
    lq_pkg::data_t      data_q [NUM_ENTRIES];

    logic [NUM_ENTRIES-1:0] alu_hit;
    lq_pkg::addr_t          alu_addr [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] wait_mem;
    logic [CNT_W-1:0]       alloc_cnt;
    logic                   cdb_fire;

    // snoop ALU results for the rob index of each waiting load
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            alu_hit[i] = 1'b0;
            alu_addr[i] = '0;
            for (int w = 0; w < WAYS; w++) begin
                if (alu_valid[w] && alu_is_ls[w] && state_q[i] == lq_pkg::ST_WAIT_ADDR &&
                    alu_rob_idx[w] == info_q[i].rob_idx) begin
                    alu_hit[i] = 1'b1;
                    alu_addr[i] = alu_data[w];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            state_d[i] = state_q[i];
            case (state_q[i])
                lq_pkg::ST_FREE:
                    if (alloc_en[i]) begin
                        state_d[i] = lq_pkg::ST_WAIT_ADDR;
                    end
                lq_pkg::ST_WAIT_ADDR:
                    if (alu_hit[i]) begin
                        state_d[i] = lq_pkg::ST_READY;
                    end
                lq_pkg::ST_READY:
                    // the cache answers within the grant cycle
                    if (ifc.rd_gnt[i]) begin
                        state_d[i] = dc_hit ? lq_pkg::ST_DONE : lq_pkg::ST_WAIT_MEM;
                    end
                lq_pkg::ST_WAIT_MEM:
                    if (mem_feedback[i]) begin
                        state_d[i] = lq_pkg::ST_DONE;
                    end
                default:
                    if (ifc.cdb_gnt[i]) begin
                        state_d[i] = lq_pkg::ST_FREE;
                    end
            endcase
        end
    end

    // status and payload views for the arbiters
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            free_mask[i] = state_q[i] == lq_pkg::ST_FREE;
            wait_mem[i] = state_q[i] == lq_pkg::ST_WAIT_MEM;
            ifc.ready[i] = state_q[i] == lq_pkg::ST_READY;
            ifc.done[i] = state_q[i] == lq_pkg::ST_DONE;
            ifc.cache_req[i] = '{addr: addr_q[i], size: info_q[i].size};
            ifc.cdb_pl[i] = '{data: data_q[i], prf_idx: info_q[i].prf_idx,
                              rob_idx: info_q[i].rob_idx, size: info_q[i].size,
                              is_signed: info_q[i].is_signed};
        end
    end

    assign alloc_cnt = CNT_W'($countones(alloc_en));
    assign cdb_fire = |ifc.cdb_gnt;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                state_q[i] <= lq_pkg::ST_FREE;
            end
            lq_num_free <= CNT_W'(NUM_ENTRIES);
        end else if (except) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                state_q[i] <= lq_pkg::ST_FREE;
            end
            lq_num_free <= CNT_W'(NUM_ENTRIES);
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                state_q[i] <= state_d[i];
            end
            lq_num_free <= lq_num_free - alloc_cnt + CNT_W'(cdb_fire);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (alloc_en[i] && state_q[i] == lq_pkg::ST_FREE) begin
                info_q[i] <= alloc_info[i];
            end
            if (alu_hit[i]) begin
                addr_q[i] <= alu_data_sel(i);
            end
            // hit data from the cache, miss data from memory
            if (state_q[i] == lq_pkg::ST_READY && ifc.rd_gnt[i] && dc_hit) begin
                data_q[i] <= dc_data;
            end else if (wait_mem[i] && mem_feedback[i]) begin
                data_q[i] <= mem_data;
            end
        end
    end

    function automatic lq_pkg::addr_t alu_data_sel(input int i);
        return alu_addr[i];
    endfunction

    a_mem_target: assert property (@(posedge clock) disable iff (!arst_n)
        (mem_feedback & ~wait_mem) == '0)
        else $error("mem_feedback aimed at an entry not waiting for memory");

    // counter kept in step with the entries that are free
    a_free_bound: assert property (@(posedge clock) disable iff (!arst_n)
        lq_num_free <= CNT_W'(NUM_ENTRIES) &&
        lq_num_free == CNT_W'($countones(free_mask)))
        else $error("free count above queue depth or out of step with free entries");

endmodule

//--- design/lq_writeback.sv
module lq_writeback #(
    parameter int NUM_ENTRIES = lq_pkg::DEF_NUM_ENTRIES
) (
    input  logic                            clock,
    input  logic                            arst_n,
    lq_entry_if.port                        ifc,
    output logic                            cdb_valid,
    output lq_pkg::data_t                   cdb_data,
    output logic [lq_pkg::PRF_IDX_W-1:0]    cdb_prf_idx,
    output logic [lq_pkg::ROB_IDX_W-1:0]    cdb_rob_idx
);

    lq_pkg::cdb_payload_t win;

    // one finished load per cycle onto the CDB
    lq_grant_mux #(
        .WIDTH     (NUM_ENTRIES),
        .payload_t (lq_pkg::cdb_payload_t)
    ) u_cdb_arb (
        .clock   (clock),
        .arst_n  (arst_n),
        .req     (ifc.done),
        .payload (ifc.cdb_pl),
        .gnt     (ifc.cdb_gnt),
        .valid   (cdb_valid),
        .sel     (win)
    );

    // unsigned loads fill with zeros
    always_comb begin
        case (win.size)
            lq_pkg::BYTE: cdb_data = {{24{win.is_signed & win.data[7]}}, win.data[7:0]};
            lq_pkg::HALF: cdb_data = {{16{win.is_signed & win.data[15]}}, win.data[15:0]};
            default:      cdb_data = win.data;
        endcase
    end

    assign cdb_prf_idx = win.prf_idx;
    assign cdb_rob_idx = win.rob_idx;

endmodule

//--- design/load_queue.sv
module load_queue #(
    parameter int NUM_ENTRIES = lq_pkg::DEF_NUM_ENTRIES,
    parameter int WAYS = lq_pkg::DEF_WAYS
) (
    input  logic                                        clock,
    input  logic                                        arst_n,
    input  logic                                        except,
    input  logic [WAYS-1:0]                             ld_en,
    input  lq_pkg::ld_issue_t [WAYS-1:0]                ld_info,
    input  logic [WAYS-1:0]                             alu_valid,
    input  logic [WAYS-1:0]                             alu_is_ls,
    input  logic [WAYS-1:0][lq_pkg::ROB_IDX_W-1:0]      alu_rob_idx,
    input  lq_pkg::addr_t [WAYS-1:0]                    alu_data,
    input  logic                                        dc_hit,
    input  lq_pkg::data_t                               dc_data,
    input  logic [NUM_ENTRIES-1:0]                      mem_feedback,
    input  lq_pkg::data_t                               mem_data,
    output logic [$clog2(NUM_ENTRIES+1)-1:0]            lq_num_free,
    output logic                                        rd_en,
    output lq_pkg::addr_t                               rd_addr,
    output lq_pkg::mem_size_t                           rd_size,
    output logic [NUM_ENTRIES-1:0]                      rd_gnt,
    output logic                                        cdb_valid,
    output lq_pkg::data_t                               cdb_data,
    output logic [lq_pkg::PRF_IDX_W-1:0]                cdb_prf_idx,
    output logic [lq_pkg::ROB_IDX_W-1:0]                cdb_rob_idx
);

    logic [NUM_ENTRIES-1:0]                 free_mask;
    logic [NUM_ENTRIES-1:0]                 alloc_en;
    lq_pkg::ld_issue_t [NUM_ENTRIES-1:0]    alloc_info;
    lq_pkg::cache_req_t                     rd_req;

    lq_entry_if #(.N(NUM_ENTRIES)) lq_if ();

    lq_alloc #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .WAYS        (WAYS)
    ) u_alloc (
        .free_mask  (free_mask),
        .ld_en      (ld_en),
        .ld_info    (ld_info),
        .alloc_en   (alloc_en),
        .alloc_info (alloc_info)
    );

    lq_entry_array #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .WAYS        (WAYS)
    ) u_array (
        .clock        (clock),
        .arst_n       (arst_n),
        .except       (except),
        .alloc_en     (alloc_en),
        .alloc_info   (alloc_info),
        .alu_valid    (alu_valid),
        .alu_is_ls    (alu_is_ls),
        .alu_rob_idx  (alu_rob_idx),
        .alu_data     (alu_data),
        .dc_hit       (dc_hit),
        .dc_data      (dc_data),
        .mem_feedback (mem_feedback),
        .mem_data     (mem_data),
        .free_mask    (free_mask),
        .lq_num_free  (lq_num_free),
        .ifc          (lq_if.array)
    );

    // one address-ready load per cycle to the data cache
    lq_grant_mux #(
        .WIDTH     (NUM_ENTRIES),
        .payload_t (lq_pkg::cache_req_t)
    ) u_cache_arb (
        .clock   (clock),
        .arst_n  (arst_n),
        .req     (lq_if.ready),
        .payload (lq_if.cache_req),
        .gnt     (lq_if.rd_gnt),
        .valid   (rd_en),
        .sel     (rd_req)
    );

    assign rd_addr = rd_req.addr;
    assign rd_size = rd_req.size;
    assign rd_gnt = lq_if.rd_gnt;

    lq_writeback #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_writeback (
        .clock       (clock),
        .arst_n      (arst_n),
        .ifc         (lq_if.port),
        .cdb_valid   (cdb_valid),
        .cdb_data    (cdb_data),
        .cdb_prf_idx (cdb_prf_idx),
        .cdb_rob_idx (cdb_rob_idx)
    );

endmodule

//--- testbench/tb_load_queue.sv
module tb_load_queue;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES = 8;
    localparam int WAYS = 2;
    localparam int CNT_W = $clog2(NUM_ENTRIES + 1);
    // five tests, forty cycles each, 100 ns per cycle
    localparam int WATCHDOG_NS = 5 * 40 * 100;

    logic                                       clock;
    logic                                       arst_n;
    logic                                       except;
    logic [WAYS-1:0]                            ld_en;
    lq_pkg::ld_issue_t [WAYS-1:0]               ld_info;
    logic [WAYS-1:0]                            alu_valid;
    logic [WAYS-1:0]                            alu_is_ls;
    logic [WAYS-1:0][lq_pkg::ROB_IDX_W-1:0]     alu_rob_idx;
    lq_pkg::addr_t [WAYS-1:0]                   alu_data;
    logic                                       dc_hit;
    lq_pkg::data_t                              dc_data;
    logic [NUM_ENTRIES-1:0]                     mem_feedback;
    lq_pkg::data_t                              mem_data;
    logic [CNT_W-1:0]                           lq_num_free;
    logic                                       rd_en;
    lq_pkg::addr_t                              rd_addr;
    lq_pkg::mem_size_t                          rd_size;
    logic [NUM_ENTRIES-1:0]                     rd_gnt;
    logic                                       cdb_valid;
    lq_pkg::data_t                              cdb_data;
    logic [lq_pkg::PRF_IDX_W-1:0]               cdb_prf_idx;
    logic [lq_pkg::ROB_IDX_W-1:0]               cdb_rob_idx;

    int errors = 0;
    int seed = 32'hf165_1039;

    load_queue #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .WAYS        (WAYS)
    ) i_dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .except       (except),
        .ld_en        (ld_en),
        .ld_info      (ld_info),
        .alu_valid    (alu_valid),
        .alu_is_ls    (alu_is_ls),
        .alu_rob_idx  (alu_rob_idx),
        .alu_data     (alu_data),
        .dc_hit       (dc_hit),
        .dc_data      (dc_data),
        .mem_feedback (mem_feedback),
        .mem_data     (mem_data),
        .lq_num_free  (lq_num_free),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_size      (rd_size),
        .rd_gnt       (rd_gnt),
        .cdb_valid    (cdb_valid),
        .cdb_data     (cdb_data),
        .cdb_prf_idx  (cdb_prf_idx),
        .cdb_rob_idx  (cdb_rob_idx)
    );

    always #50 clock = ~clock;

    task automatic check_data(input string name, input lq_pkg::data_t exp,
                              input lq_pkg::data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input lq_pkg::addr_t exp,
                              input lq_pkg::addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected addr %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_size(input string name, input lq_pkg::mem_size_t exp,
                              input lq_pkg::mem_size_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected size %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_gnt(input string name, input logic [NUM_ENTRIES-1:0] exp,
                             input logic [NUM_ENTRIES-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected grant %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input logic [lq_pkg::PRF_IDX_W-1:0] exp,
                             input logic [lq_pkg::PRF_IDX_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected index %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected free count %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    function automatic lq_pkg::ld_issue_t make_info(input lq_pkg::mem_size_t size,
                                                    input logic [lq_pkg::ROB_IDX_W-1:0] rob,
                                                    input logic [lq_pkg::PRF_IDX_W-1:0] prf,
                                                    input logic sgn);
        lq_pkg::ld_issue_t info;
        info.size = size;
        info.rob_idx = rob;
        info.prf_idx = prf;
        info.is_signed = sgn;
        return info;
    endfunction

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic alloc_one(input lq_pkg::ld_issue_t info);
        ld_info[0] = info;
        ld_en[0] = 1'b1;
        next_cycle();
        ld_en = '0;
    endtask

    task automatic send_addr(input int way, input logic [lq_pkg::ROB_IDX_W-1:0] rob,
                             input lq_pkg::addr_t addr);
        alu_valid[way] = 1'b1;
        alu_is_ls[way] = 1'b1;
        alu_rob_idx[way] = rob;
        alu_data[way] = addr;
        next_cycle();
        alu_valid = '0;
        alu_is_ls = '0;
    endtask

    // waits for a cache read, answers it, then moves to the next cycle
    task automatic await_rd(input string name, input int max_wait,
                            input lq_pkg::addr_t exp_addr, input lq_pkg::mem_size_t exp_size,
                            input logic [NUM_ENTRIES-1:0] exp_gnt,
                            input logic hit, input lq_pkg::data_t data);
        int waited;
        waited = 0;
        while (!rd_en && waited < max_wait) begin
            next_cycle();
            waited++;
        end
        if (!rd_en) begin
            $display("%s: no cache read within %0d cycles", name, max_wait);
            errors++;
        end else begin
            check_addr(name, exp_addr, rd_addr);
            check_size(name, exp_size, rd_size);
            check_gnt(name, exp_gnt, rd_gnt);
            dc_hit = hit;
            dc_data = data;
            next_cycle();
            dc_hit = 1'b0;
        end
    endtask

    task automatic await_cdb(input string name, input int max_wait,
                             input lq_pkg::data_t exp_data,
                             input logic [lq_pkg::PRF_IDX_W-1:0] exp_prf,
                             input logic [lq_pkg::ROB_IDX_W-1:0] exp_rob);
        int waited;
        waited = 0;
        while (!cdb_valid && waited < max_wait) begin
            next_cycle();
            waited++;
        end
        if (!cdb_valid) begin
            $display("%s: no CDB broadcast within %0d cycles", name, max_wait);
            errors++;
        end else begin
            check_data(name, exp_data, cdb_data);
            check_idx(name, exp_prf, cdb_prf_idx);
            check_idx(name, {1'b0, exp_rob}, {1'b0, cdb_rob_idx});
            next_cycle();
        end
    endtask

    task automatic test_word_hit();
        lq_pkg::addr_t addr;
        lq_pkg::data_t data;
        addr = lq_pkg::addr_t'($random(seed));
        data = lq_pkg::data_t'($random(seed));
        alloc_one(make_info(lq_pkg::WORD, 5'd1, 6'd33, 1'b0));
        send_addr(0, 5'd1, addr);
        // empty queue, so the load sits in entry 0
        // read in the cycle after capture, broadcast one cycle later
        await_rd("word_hit", 0, addr, lq_pkg::WORD, NUM_ENTRIES'(1), 1'b1, data);
        await_cdb("word_hit", 0, data, 6'd33, 5'd1);
    endtask

    task automatic test_extension();
        lq_pkg::addr_t addr;
        lq_pkg::data_t raw;
        lq_pkg::data_t exp;
        lq_pkg::mem_size_t size;
        logic sgn;
        string name;
        for (int k = 0; k < 4; k++) begin
            size = (k < 2) ? lq_pkg::BYTE : lq_pkg::HALF;
            sgn = (k % 2 == 1);
            name = $sformatf("extension_%0d", k);
            addr = lq_pkg::addr_t'($random(seed));
            // top bit of both the byte and the half is set
            raw = lq_pkg::data_t'($random(seed)) | 32'h0000_8080;
            if (size == lq_pkg::BYTE) begin
                exp = sgn ? {24'hff_ffff, raw[7:0]} : {24'h00_0000, raw[7:0]};
            end else begin
                exp = sgn ? {16'hffff, raw[15:0]} : {16'h0000, raw[15:0]};
            end
            alloc_one(make_info(size, 5'(8 + k), 6'(40 + k), sgn));
            send_addr(0, 5'(8 + k), addr);
            await_rd(name, 0, addr, size, NUM_ENTRIES'(1), 1'b1, raw);
            await_cdb(name, 0, exp, 6'(40 + k), 5'(8 + k));
        end
    endtask

    task automatic test_miss();
        lq_pkg::addr_t addr;
        lq_pkg::data_t fill;
        addr = lq_pkg::addr_t'($random(seed));
        fill = lq_pkg::data_t'($random(seed));
        alloc_one(make_info(lq_pkg::WORD, 5'd5, 6'd20, 1'b0));
        send_addr(0, 5'd5, addr);
        await_rd("miss", 4, addr, lq_pkg::WORD, NUM_ENTRIES'(1), 1'b0, '0);
        for (int i = 0; i < 3; i++) begin
            if (cdb_valid) begin
                $display("miss: CDB broadcast before memory answered");
                errors++;
            end
            next_cycle();
        end
        // memory answers entry 0
        mem_feedback = NUM_ENTRIES'(1);
        mem_data = fill;
        next_cycle();
        mem_feedback = '0;
        await_cdb("miss", 0, fill, 6'd20, 5'd5);
    endtask

    task automatic test_dual_issue();
        lq_pkg::data_t data;
        logic seen_a;
        logic seen_b;
        data = lq_pkg::data_t'($random(seed));
        ld_info[0] = make_info(lq_pkg::WORD, 5'd3, 6'd10, 1'b0);
        ld_info[1] = make_info(lq_pkg::WORD, 5'd4, 6'd11, 1'b0);
        ld_en = '1;
        next_cycle();
        ld_en = '0;
        check_count("dual_alloc", CNT_W'(NUM_ENTRIES - 2), lq_num_free);
        dc_hit = 1'b1;
        dc_data = data;
        // second load gets its address first
        send_addr(1, 5'd4, lq_pkg::addr_t'($random(seed)));
        send_addr(0, 5'd3, lq_pkg::addr_t'($random(seed)));
        seen_a = 1'b0;
        seen_b = 1'b0;
        for (int i = 0; i < 10 && !(seen_a && seen_b); i++) begin
            if (cdb_valid) begin
                check_data("dual_issue", data, cdb_data);
                if (cdb_rob_idx == 5'd3) begin
                    seen_a = 1'b1;
                    check_idx("dual_issue", 6'd10, cdb_prf_idx);
                end else if (cdb_rob_idx == 5'd4) begin
                    seen_b = 1'b1;
                    check_idx("dual_issue", 6'd11, cdb_prf_idx);
                end else begin
                    $display("dual_issue: broadcast carries an unknown ROB index");
                    errors++;
                end
            end
            next_cycle();
        end
        dc_hit = 1'b0;
        if (!(seen_a && seen_b)) begin
            $display("dual_issue: a load never reached the CDB");
            errors++;
        end
        check_count("dual_drain", CNT_W'(NUM_ENTRIES), lq_num_free);
    endtask

    task automatic test_flush();
        for (int i = 0; i < NUM_ENTRIES / WAYS; i++) begin
            ld_info[0] = make_info(lq_pkg::WORD, 5'(16 + 2 * i), 6'(i), 1'b0);
            ld_info[1] = make_info(lq_pkg::WORD, 5'(17 + 2 * i), 6'(8 + i), 1'b0);
            ld_en = '1;
            next_cycle();
        end
        ld_en = '0;
        check_count("flush_full", '0, lq_num_free);
        send_addr(0, 5'd16, lq_pkg::addr_t'($random(seed)));
        if (!rd_en) begin
            $display("flush: load with a known address did not read the cache");
            errors++;
        end
        except = 1'b1;
        next_cycle();
        except = 1'b0;
        check_count("flush_free", CNT_W'(NUM_ENTRIES), lq_num_free);
        for (int i = 0; i < 5; i++) begin
            if (rd_en || cdb_valid) begin
                $display("flush: cache read or CDB broadcast after the flush");
                errors++;
            end
            next_cycle();
        end
    endtask

    initial begin
        clock = 1'b0;
        arst_n = 1'b0;
        except = 1'b0;
        ld_en = '0;
        ld_info = '0;
        alu_valid = '0;
        alu_is_ls = '0;
        alu_rob_idx = '0;
        alu_data = '0;
        dc_hit = 1'b0;
        dc_data = '0;
        mem_feedback = '0;
        mem_data = '0;
        repeat (5) @(posedge clock);
        #10;
        arst_n = 1'b1;
        check_count("reset", CNT_W'(NUM_ENTRIES), lq_num_free);
        if (rd_en || cdb_valid) begin
            $display("reset: cache read or CDB broadcast active after reset");
            errors++;
        end
        test_word_hit();
        test_extension();
        test_miss();
        test_dual_issue();
        test_flush();
        $display("tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- filelist.f
design/lq_pkg.sv
design/lq_entry_if.sv
design/lq_alloc.sv
design/lq_grant_mux.sv
design/lq_entry_array.sv
design/lq_writeback.sv
design/load_queue.sv
testbench/tb_load_queue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the load queue testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_load_queue -f filelist.f -o tb_load_queue
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_load_queue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
